// ==== verilog/csr_pkg.sv ====
/*
 * shared CSR definitions: address map, op and cause types,
 * widths, mstatus bit positions, read-modify-write function
 */

package csr_pkg;

  localparam int XLEN           = 32;
  localparam int N_FIXED_EVENTS = 11;  // built-in counter events
  localparam int PCCR_INDEX_W   = 5;

  // mstatus fields kept in hardware
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;  // two bits, always machine mode

  //////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    MSTATUS   = 12'h300,
    MISA      = 12'h301,
    MTVEC     = 12'h305,  // reads back the boot address
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    PCCR_BASE = 12'h780,  // counter n sits at base + n
    PCCR_ALL  = 12'h79F,  // write hits every counter
    PCER      = 12'h7A0,
    PCMR      = 12'h7A1,
    MHARTID   = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_WRITE,
    OP_SET,
    OP_CLEAR
  } csr_op_e;

  // [5] interrupt flag, [4:0] code
  typedef logic [5:0] exc_cause_t;

  //////////////////////////////////////////////////////////////
  // read-modify-write
  //////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] csr_apply_op(
    input csr_op_e         op,
    input logic [XLEN-1:0] old_val,
    input logic [XLEN-1:0] wval
  );
    logic [XLEN-1:0] res;
    case (op)
      OP_WRITE: res = wval;
      OP_SET:   res = old_val | wval;
      OP_CLEAR: res = old_val & ~wval;
      default:  res = old_val;  // no-op keeps the old value
    endcase
    return res;
  endfunction

endpackage

// ==== verilog/csr_access_ctrl.sv ====
/*
 * CSR access control: address decode, read mux, op apply,
 * per-register write strobes
 */

`timescale 1ns/100ps

module csr_access_ctrl #(
  parameter int N_CNT = 13,
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic                                csr_access_i,
  input  csr_pkg::csr_addr_e                  csr_addr_i,
  input  csr_pkg::csr_op_e                    csr_op_i,
  input  logic [csr_pkg::XLEN-1:0]            csr_wdata_i,
  input  logic [3:0]                          core_id_i,
  input  logic [5:0]                          cluster_id_i,
  input  logic [csr_pkg::XLEN-1:0]            boot_addr_i,
  input  logic                                mie_i,
  input  logic                                mpie_i,
  input  logic [csr_pkg::XLEN-1:0]            mepc_i,
  input  csr_pkg::exc_cause_t                 mcause_i,
  input  logic [N_CNT-1:0]                    pcer_i,
  input  logic [1:0]                          pcmr_i,
  input  logic [N_CNT-1:0][csr_pkg::XLEN-1:0] pccr_i,
  output logic [csr_pkg::XLEN-1:0]            csr_rdata_o,
  output logic [csr_pkg::XLEN-1:0]            csr_wdata_o,  // already merged with old value
  output logic                                mstatus_we_o,
  output logic                                mepc_we_o,
  output logic                                mcause_we_o,
  output logic                                pcer_we_o,
  output logic                                pcmr_we_o,
  output logic [N_CNT-1:0]                    pccr_we_o
);

  import csr_pkg::*;

  // misa: MXL=1 (rv32), I and C always, E and M by parameter
  localparam logic [XLEN-1:0] MISA_VALUE = (XLEN'(1) << 30)
                                         | (XLEN'(RV32M) << 12)
                                         | (XLEN'(1) << 8)
                                         | (XLEN'(RV32E) << 4)
                                         | (XLEN'(1) << 2);

  logic [11:0]             addr;
  logic [PCCR_INDEX_W-1:0] pccr_idx;
  logic                    is_pccr;      // anywhere in 0x780..0x79f
  logic                    pccr_all;
  logic                    pccr_valid;   // single counter that exists
  logic                    we;
  logic [XLEN-1:0]         rdata_int;

  //////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////

  assign addr       = csr_addr_i;
  assign pccr_idx   = addr[PCCR_INDEX_W-1:0];
  assign is_pccr    = (addr[11:PCCR_INDEX_W] == PCCR_BASE[11:PCCR_INDEX_W]);
  assign pccr_all   = (addr == PCCR_ALL);
  assign pccr_valid = is_pccr && !pccr_all && (pccr_idx < N_CNT);

  // read mux
  always_comb begin
    rdata_int = '0;
    case (csr_addr_i)
      MSTATUS: begin
        rdata_int[MSTATUS_MPP_LSB +: 2] = 2'b11;  // mpp fixed to M
        rdata_int[MSTATUS_MPIE_BIT]     = mpie_i;
        rdata_int[MSTATUS_MIE_BIT]      = mie_i;
      end
      MISA:    rdata_int = MISA_VALUE;
      MTVEC:   rdata_int = boot_addr_i;
      MEPC:    rdata_int = mepc_i;
      MCAUSE:  rdata_int = {mcause_i[5], 26'b0, mcause_i[4:0]};
      MHARTID: rdata_int = {21'b0, cluster_id_i, 1'b0, core_id_i};
      PCER:    rdata_int[N_CNT-1:0] = pcer_i;
      PCMR:    rdata_int[1:0] = pcmr_i;
      default: begin
        if (pccr_valid) begin
          rdata_int = pccr_i[pccr_idx];
        end
      end  // PCCR_ALL and unknown addresses read 0
    endcase
  end

  assign csr_rdata_o = csr_access_i ? rdata_int : '0;

  //////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////

  assign csr_wdata_o = csr_apply_op(csr_op_i, rdata_int, csr_wdata_i);
  assign we          = csr_access_i && (csr_op_i != OP_NONE);

  assign mstatus_we_o = we && (csr_addr_i == MSTATUS);
  assign mepc_we_o    = we && (csr_addr_i == MEPC);
  assign mcause_we_o  = we && (csr_addr_i == MCAUSE);
  assign pcer_we_o    = we && (csr_addr_i == PCER);
  assign pcmr_we_o    = we && (csr_addr_i == PCMR);

  for (genvar c = 0; c < N_CNT; c++) begin : g_pccr_we
    assign pccr_we_o[c] = we && is_pccr && (pccr_all || pccr_idx == PCCR_INDEX_W'(c));
  end

  // at most one register strobe per access
  always_comb begin
    assert ($onehot0({mstatus_we_o, mepc_we_o, mcause_we_o, pcer_we_o, pcmr_we_o,
                      |pccr_we_o}))
      else $error("csr_access_ctrl: more than one write strobe");
  end

endmodule

// ==== verilog/machine_trap_regs.sv ====
/*
 * machine trap state: mstatus (mie, mpie), mepc, mcause
 * trap save, mret, CSR writes
 */

`timescale 1ns/100ps

module machine_trap_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     mstatus_we_i,
  input  logic                     mepc_we_i,
  input  logic                     mcause_we_i,
  input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
  input  logic                     csr_save_cause_i,    // trap entry pulse
  input  logic                     csr_save_if_i,
  input  logic                     csr_save_id_i,
  input  logic [csr_pkg::XLEN-1:0] pc_if_i,
  input  logic [csr_pkg::XLEN-1:0] pc_id_i,
  input  csr_pkg::exc_cause_t      csr_cause_i,
  input  logic                     csr_restore_mret_i,  // mret pulse
  output logic                     mie_o,
  output logic                     mpie_o,
  output logic [csr_pkg::XLEN-1:0] mepc_o,
  output csr_pkg::exc_cause_t      mcause_o
);

  import csr_pkg::*;

  logic [XLEN-1:0] exception_pc;

  // IF pc only when IF alone is selected, ID otherwise
  assign exception_pc = (csr_save_if_i && !csr_save_id_i) ? pc_if_i : pc_id_i;

  //////////////////////////////////////////////////////////////
  // mstatus
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_o  <= 1'b0;
      mpie_o <= 1'b0;
    end else if (csr_save_cause_i) begin
      mpie_o <= mie_o;  // stack the enable
      mie_o  <= 1'b0;
    end else if (csr_restore_mret_i) begin
      mie_o  <= mpie_o;
      mpie_o <= 1'b1;
    end else if (mstatus_we_i) begin
      mie_o  <= csr_wdata_i[MSTATUS_MIE_BIT];
      mpie_o <= csr_wdata_i[MSTATUS_MPIE_BIT];
    end
  end

  //////////////////////////////////////////////////////////////
  // mepc and mcause where a trap beats a csr write
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_o <= '0;
    end else if (csr_save_cause_i) begin
      mepc_o <= exception_pc;
    end else if (mepc_we_i) begin
      mepc_o <= csr_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcause_o <= '0;
    end else if (csr_save_cause_i) begin
      mcause_o <= csr_cause_i;
    end else if (mcause_we_i) begin
      mcause_o <= {csr_wdata_i[XLEN-1], csr_wdata_i[4:0]};  // irq flag + code
    end
  end

  // the controller never enters and leaves a trap in one cycle
  a_save_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_cause_i && csr_restore_mret_i))
    else $error("machine_trap_regs: trap save and mret together");

endmodule

// ==== verilog/perf_event_ctrl.sv ====
/*
 * performance event control: PCER, PCMR, event vector,
 * registered per-counter increments
 */

`timescale 1ns/100ps

module perf_event_ctrl #(
  parameter  int N_EXT_CNT = 2,
  localparam int N_CNT     = csr_pkg::N_FIXED_EVENTS + N_EXT_CNT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     if_valid_i,
  input  logic                     id_valid_i,
  input  logic                     is_compressed_i,
  input  logic                     is_decoding_i,
  input  logic                     imiss_i,
  input  logic                     pc_set_i,
  input  logic                     jump_i,
  input  logic                     branch_i,
  input  logic                     branch_taken_i,
  input  logic                     mem_load_i,
  input  logic                     mem_store_i,
  input  logic [N_EXT_CNT-1:0]     ext_counters_i,
  input  logic                     pcer_we_i,
  input  logic                     pcmr_we_i,
  input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
  output logic [N_CNT-1:0]         pcer_o,     // per-counter enable
  output logic [1:0]               pcmr_o,     // [0] global enable, [1] saturate
  output logic [N_CNT-1:0]         cnt_inc_o
);

  import csr_pkg::*;

  logic [N_CNT-1:0] events;

  assign events[0]  = 1'b1;                     // cycles
  assign events[1]  = if_valid_i;               // fetched instructions
  assign events[2]  = 1'b0;                     // reserved
  assign events[3]  = 1'b0;                     // reserved
  assign events[4]  = imiss_i & ~pc_set_i;      // fetch stall, not a redirect
  assign events[5]  = mem_load_i;
  assign events[6]  = mem_store_i;
  assign events[7]  = jump_i;
  assign events[8]  = branch_i;
  assign events[9]  = branch_taken_i;
  assign events[10] = id_valid_i & is_decoding_i & is_compressed_i;
  assign events[N_FIXED_EVENTS +: N_EXT_CNT] = ext_counters_i;

  //////////////////////////////////////////////////////////////
  // mode / enable registers and increment stage
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_o    <= '0;
      pcmr_o    <= 2'b11;  // enabled and saturating out of reset
      cnt_inc_o <= '0;
    end else begin
      if (pcer_we_i) begin
        pcer_o <= csr_wdata_i[N_CNT-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_o <= csr_wdata_i[1:0];
      end
      cnt_inc_o <= events & pcer_o & {N_CNT{pcmr_o[0]}};  // one cycle ahead of the add
    end
  end

endmodule

// ==== verilog/perf_counter_bank.sv ====
/*
 * performance counter registers, saturating or wrapping
 * increment, strobed writes
 */

`timescale 1ns/100ps

module perf_counter_bank #(
  parameter int N_CNT = 13
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [N_CNT-1:0]                    cnt_inc_i,
  input  logic                                saturate_i,  // PCMR[1]
  input  logic [N_CNT-1:0]                    pccr_we_i,
  input  logic [csr_pkg::XLEN-1:0]            csr_wdata_i,
  output logic [N_CNT-1:0][csr_pkg::XLEN-1:0] pccr_o
);

  //////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////

  for (genvar c = 0; c < N_CNT; c++) begin : g_cnt
    logic at_max;

    assign at_max = &pccr_o[c];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        pccr_o[c] <= '0;
      end else if (pccr_we_i[c]) begin
        pccr_o[c] <= csr_wdata_i;  // write beats increment
      end else if (cnt_inc_i[c] && !(saturate_i && at_max)) begin
        pccr_o[c] <= pccr_o[c] + 1'b1;  // wraps when not saturating
      end
    end

    // saturating counter sticks at all ones unless written
    a_sat_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (saturate_i && at_max && !pccr_we_i[c]) |=> (pccr_o[c] != '0))
      else $error("perf_counter_bank: counter %0d wrapped while saturating", c);
  end

endmodule

// ==== verilog/csr_file.sv ====
/*
 * top level of the machine-mode CSR file
 * access control, trap registers, counter control and counters
 */

`timescale 1ns/100ps

module csr_file #(
  parameter int N_EXT_CNT = 2,     // at least 1, 31 counters max
  parameter bit RV32E     = 1'b0,
  parameter bit RV32M     = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [3:0]               core_id_i,
  input  logic [5:0]               cluster_id_i,
  input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
  // core CSR port
  input  logic                     csr_access_i,
  input  csr_pkg::csr_addr_e       csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
  // traps
  output logic                     m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0] mepc_o,
  input  logic [csr_pkg::XLEN-1:0] pc_if_i,
  input  logic [csr_pkg::XLEN-1:0] pc_id_i,
  input  logic                     csr_save_if_i,
  input  logic                     csr_save_id_i,
  input  logic                     csr_save_cause_i,
  input  csr_pkg::exc_cause_t      csr_cause_i,
  input  logic                     csr_restore_mret_i,
  // counter events
  input  logic                     if_valid_i,
  input  logic                     id_valid_i,
  input  logic                     is_compressed_i,
  input  logic                     is_decoding_i,
  input  logic                     imiss_i,
  input  logic                     pc_set_i,
  input  logic                     jump_i,
  input  logic                     branch_i,
  input  logic                     branch_taken_i,
  input  logic                     mem_load_i,
  input  logic                     mem_store_i,
  input  logic [N_EXT_CNT-1:0]     ext_counters_i
);

  import csr_pkg::*;

  localparam int N_CNT = N_FIXED_EVENTS + N_EXT_CNT;

  logic                        mpie;
  exc_cause_t                  mcause;
  logic [XLEN-1:0]             csr_wdata;    // merged write value
  logic                        mstatus_we;
  logic                        mepc_we;
  logic                        mcause_we;
  logic                        pcer_we;
  logic                        pcmr_we;
  logic [N_CNT-1:0]            pccr_we;
  logic [N_CNT-1:0]            pcer;
  logic [1:0]                  pcmr;
  logic [N_CNT-1:0]            cnt_inc;
  logic [N_CNT-1:0][XLEN-1:0]  pccr;

  //////////////////////////////////////////////////////////////
  // access control
  //////////////////////////////////////////////////////////////

  csr_access_ctrl #(
    .N_CNT (N_CNT),
    .RV32E (RV32E),
    .RV32M (RV32M)
  ) i_csr_access_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .mie_i        (m_irq_enable_o),
    .mpie_i       (mpie),
    .mepc_i       (mepc_o),
    .mcause_i     (mcause),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_i       (pccr),
    .csr_rdata_o  (csr_rdata_o),
    .csr_wdata_o  (csr_wdata),
    .mstatus_we_o (mstatus_we),
    .mepc_we_o    (mepc_we),
    .mcause_we_o  (mcause_we),
    .pcer_we_o    (pcer_we),
    .pcmr_we_o    (pcmr_we),
    .pccr_we_o    (pccr_we)
  );

  // trap state, mie drives the irq enable directly
  machine_trap_regs i_machine_trap_regs (
    .clk                (clk),
    .rst_n              (rst_n),
    .mstatus_we_i       (mstatus_we),
    .mepc_we_i          (mepc_we),
    .mcause_we_i        (mcause_we),
    .csr_wdata_i        (csr_wdata),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_cause_i        (csr_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .mie_o              (m_irq_enable_o),
    .mpie_o             (mpie),
    .mepc_o             (mepc_o),
    .mcause_o           (mcause)
  );

  //////////////////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////////////////

  perf_event_ctrl #(
    .N_EXT_CNT (N_EXT_CNT)
  ) i_perf_event_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .if_valid_i      (if_valid_i),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .ext_counters_i  (ext_counters_i),
    .pcer_we_i       (pcer_we),
    .pcmr_we_i       (pcmr_we),
    .csr_wdata_i     (csr_wdata),
    .pcer_o          (pcer),
    .pcmr_o          (pcmr),
    .cnt_inc_o       (cnt_inc)
  );

  perf_counter_bank #(
    .N_CNT (N_CNT)
  ) i_perf_counter_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .cnt_inc_i   (cnt_inc),
    .saturate_i  (pcmr[1]),
    .pccr_we_i   (pccr_we),
    .csr_wdata_i (csr_wdata),
    .pccr_o      (pccr)
  );

endmodule

// ==== verif/tb_csr_ref.svh ====
/*
 * reference model of the CSR file and the galois LFSR,
 * included into the testbench module
 */

`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

  // galois lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // write / set / clear on the old read value
  function automatic logic [XLEN-1:0] merge_op(input csr_op_e op,
                                               input logic [XLEN-1:0] old_v,
                                               input logic [XLEN-1:0] wv);
    case (op)
      OP_WRITE: return wv;
      OP_SET:   return old_v | wv;
      OP_CLEAR: return old_v & ~wv;
      default:  return old_v;
    endcase
  endfunction

  // what the core sees on a read of addr
  function automatic logic [XLEN-1:0] expected_rdata(input logic [11:0] addr);
    logic [XLEN-1:0] v;
    v = '0;
    case (addr)
      MSTATUS: v = 32'h1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3);  // mpp = M
      MISA:    v = 32'h4000_1104;  // rv32 I C M
      MTVEC:   v = boot_addr_i;
      MEPC:    v = m_mepc;
      MCAUSE:  v = (32'(m_mcause[5]) << 31) | 32'(m_mcause[4:0]);  // irq flag on top
      MHARTID: v = (32'(cluster_id_i) << 5) | 32'(core_id_i);
      PCER:    v = 32'(m_pcer);
      PCMR:    v = 32'(m_pcmr);
      default: begin
        if (addr[11:5] == PCCR_BASE[11:5] && int'(addr[4:0]) < N_CNT) begin
          v = m_cnt[int'(addr[4:0])];
        end
      end  // PCCR_ALL, missing counters, unknown
    endcase
    return v;
  endfunction

  // one clock edge of the whole register file
  function automatic void model_step(input logic acc, input logic [11:0] addr,
                                     input csr_op_e op, input logic [XLEN-1:0] wd,
                                     input logic [N_CNT-1:0] ev);
    logic [XLEN-1:0] nv;
    logic            we;
    logic            pccr_hit;
    nv       = merge_op(op, expected_rdata(addr), wd);
    we       = acc && (op != OP_NONE);
    pccr_hit = we && (addr[11:5] == PCCR_BASE[11:5]);
    // counters take last edge's increment and a write wins
    for (int c = 0; c < N_CNT; c++) begin
      if (pccr_hit && (addr[4:0] == 5'd31 || addr[4:0] == 5'(c))) begin
        m_cnt[c] = nv;
      end else if (m_inc[c] && !(m_pcmr[1] && m_cnt[c] == '1)) begin
        m_cnt[c] = m_cnt[c] + 1;  // wraps when not saturating
      end
    end
    m_inc = ev & m_pcer & {N_CNT{m_pcmr[0]}};  // old enable and mode
    // trap beats csr writes on the machine regs
    if (nxt_save) begin
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mepc   = nxt_sel_if ? nxt_pc_if : nxt_pc_id;
      m_mcause = nxt_cause;
    end else begin
      if (nxt_mret) begin
        m_mie  = m_mpie;
        m_mpie = 1'b1;
      end else if (we && addr == MSTATUS) begin
        m_mie  = nv[MSTATUS_MIE_BIT];
        m_mpie = nv[MSTATUS_MPIE_BIT];
      end
      if (we && addr == MEPC) m_mepc = nv;
      if (we && addr == MCAUSE) m_mcause = {nv[31], nv[4:0]};
    end
    if (we && addr == PCER) m_pcer = nv[N_CNT-1:0];
    if (we && addr == PCMR) m_pcmr = nv[1:0];
  endfunction

`endif

// ==== verif/tb_csr_file.sv ====
/*
 * testbench for the CSR file: clock, reset, stimulus sequences,
 * read-back comparison against the reference model, watchdog
 */

`timescale 1ns/100ps

module tb_csr_file;

  import csr_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int N_EXT_CNT   = 2;
  localparam int N_CNT       = N_FIXED_EVENTS + N_EXT_CNT;
  localparam int N_RAND      = 100;               // random op + read-back pairs
  localparam int TEST_CYCLES = 2 * N_RAND + 170;  // all sequences with some slack

  logic                 clk;
  logic                 rst_n;
  logic [3:0]           core_id_i;
  logic [5:0]           cluster_id_i;
  logic [XLEN-1:0]      boot_addr_i;
  logic                 csr_access_i;
  csr_addr_e            csr_addr_i;
  logic [XLEN-1:0]      csr_wdata_i;
  csr_op_e              csr_op_i;
  logic [XLEN-1:0]      csr_rdata_o;
  logic                 m_irq_enable_o;
  logic [XLEN-1:0]      mepc_o;
  logic [XLEN-1:0]      pc_if_i;
  logic [XLEN-1:0]      pc_id_i;
  logic                 csr_save_if_i;
  logic                 csr_save_id_i;
  logic                 csr_save_cause_i;
  exc_cause_t           csr_cause_i;
  logic                 csr_restore_mret_i;
  logic                 if_valid_i;
  logic                 id_valid_i;
  logic                 is_compressed_i;
  logic                 is_decoding_i;
  logic                 imiss_i;
  logic                 pc_set_i;
  logic                 jump_i;
  logic                 branch_i;
  logic                 branch_taken_i;
  logic                 mem_load_i;
  logic                 mem_store_i;
  logic [N_EXT_CNT-1:0] ext_counters_i;

  // reference model state
  logic                 m_mie    = 1'b0;
  logic                 m_mpie   = 1'b0;
  logic [XLEN-1:0]      m_mepc   = '0;
  exc_cause_t           m_mcause = '0;
  logic [N_CNT-1:0]     m_pcer   = '0;
  logic [1:0]           m_pcmr   = 2'b11;
  logic [N_CNT-1:0]     m_inc    = '0;  // registered increments
  logic [XLEN-1:0]      m_cnt [N_CNT];
  logic [31:0]          lfsr_state = 32'h6e1c;

  // trap, mret and events for the next driven cycle
  logic                 nxt_save   = 1'b0;
  logic                 nxt_sel_if = 1'b0;
  logic [XLEN-1:0]      nxt_pc_if  = '0;
  logic [XLEN-1:0]      nxt_pc_id  = '0;
  exc_cause_t           nxt_cause  = '0;
  logic                 nxt_mret   = 1'b0;
  logic                 nxt_load   = 1'b0;
  logic                 nxt_store  = 1'b0;
  logic [N_EXT_CNT-1:0] nxt_ext    = '0;

  logic                 checking  = 1'b0;
  logic [XLEN-1:0]      exp_rdata = '0;
  logic                 exp_mie   = 1'b0;
  logic [XLEN-1:0]      exp_mepc  = '0;

  // registers read right after reset
  logic [11:0] addr_list [6] = '{MSTATUS, MISA, MTVEC, MHARTID, PCMR, PCER};

  `include "tb_csr_ref.svh"

  csr_file #(
    .N_EXT_CNT (N_EXT_CNT),
    .RV32E     (1'b0),
    .RV32M     (1'b1)
  ) i_csr_file (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic value_mismatch(input string name, input logic [XLEN-1:0] expv,
                                input logic [XLEN-1:0] actv);
    $display("CHECK FAILED %s expected %08h actual %08h at %0t", name, expv, actv, $time);
    $display(">>> FAIL");
    $fatal(1, "%s does not match", name);
  endtask

  // drive one cycle, then advance the model by one edge
  task automatic drive_cycle(input logic acc, input logic [11:0] addr,
                             input csr_op_e op, input logic [XLEN-1:0] wd);
    @(posedge clk);
    exp_rdata          <= acc ? expected_rdata(addr) : '0;
    exp_mie            <= m_mie;
    exp_mepc           <= m_mepc;
    csr_access_i       <= acc;
    csr_addr_i         <= csr_addr_e'(addr);
    csr_op_i           <= op;
    csr_wdata_i        <= wd;
    csr_save_cause_i   <= nxt_save;
    csr_save_if_i      <= nxt_save & nxt_sel_if;
    csr_save_id_i      <= nxt_save & ~nxt_sel_if;
    pc_if_i            <= nxt_pc_if;
    pc_id_i            <= nxt_pc_id;
    csr_cause_i        <= nxt_cause;
    csr_restore_mret_i <= nxt_mret;
    mem_load_i         <= nxt_load;
    mem_store_i        <= nxt_store;
    ext_counters_i     <= nxt_ext;
    model_step(acc, addr, op, wd, {nxt_ext, 4'b0, nxt_store, nxt_load, 4'b0, 1'b1});
    nxt_save = 1'b0;  // pulses last one cycle
    nxt_mret = 1'b0;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 12'h000, OP_NONE, '0);
  endtask

  task automatic read_csr(input logic [11:0] addr);
    drive_cycle(1'b1, addr, OP_NONE, '0);
  endtask

  // model against a value fixed by the stimulus
  task automatic model_expect(input logic [11:0] addr, input logic [XLEN-1:0] value);
    assert (expected_rdata(addr) === value)
      else value_mismatch($sformatf("model of csr %03h", addr), value, expected_rdata(addr));
  endtask

  // cycle counter from 0xfffffffe over exactly 4 increments
  task automatic run_cycle_counter(input logic sat, input logic [XLEN-1:0] expv);
    drive_cycle(1'b1, PCMR, OP_WRITE, {30'd0, sat, 1'b0});  // counting off
    drive_cycle(1'b1, PCER, OP_WRITE, 32'h1);
    drive_cycle(1'b1, PCCR_BASE, OP_WRITE, 32'hFFFF_FFFE);
    drive_cycle(1'b1, PCMR, OP_SET, 32'h1);
    repeat (3) idle_cycle();
    drive_cycle(1'b1, PCMR, OP_CLEAR, 32'h1);
    repeat (2) idle_cycle();  // drain the increment stage
    model_expect(PCCR_BASE, expv);
    read_csr(PCCR_BASE);
  endtask

  ////////////////////////////////////////////////////////////
  // compare and watchdog
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (checking) begin
      assert (csr_rdata_o === exp_rdata)
        else value_mismatch("csr_rdata_o", exp_rdata, csr_rdata_o);
      assert (m_irq_enable_o === exp_mie)
        else value_mismatch("m_irq_enable_o", 32'(exp_mie), 32'(m_irq_enable_o));
      assert (mepc_o === exp_mepc)
        else value_mismatch("mepc_o", exp_mepc, mepc_o);
    end
  end

  initial begin
    #((TEST_CYCLES * 2 + 100) * CLK_PERIOD);
    $display(">>> FAIL");
    $fatal(1, "timeout, the test did not finish within %0d cycles", TEST_CYCLES * 2 + 100);
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [11:0] addr;
    csr_op_e     op;
    logic        acc;
    int          n_load;
    int          n_store;
    int          n_ext0;
    int          n_ext1;
    rst_n = 1'b0;
    core_id_i = 4'h9;
    cluster_id_i = 6'h2b;
    boot_addr_i = 32'h1c00_8000;
    csr_access_i = 1'b0;
    csr_addr_i = MSTATUS;
    csr_wdata_i = '0;
    csr_op_i = OP_NONE;
    {pc_if_i, pc_id_i} = '0;
    {csr_save_if_i, csr_save_id_i, csr_save_cause_i, csr_restore_mret_i} = '0;
    csr_cause_i = '0;
    {if_valid_i, id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i} = '0;
    {jump_i, branch_i, branch_taken_i, mem_load_i, mem_store_i} = '0;
    ext_counters_i = '0;
    for (int c = 0; c < N_CNT; c++) m_cnt[c] = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    checking <= 1'b1;

    // reset values and identity registers
    foreach (addr_list[i]) read_csr(addr_list[i]);

    // random ops on the writable machine regs and PCER
    for (int i = 0; i < N_RAND; i++) begin
      case (rand_bits(2))
        0: addr = MSTATUS;
        1: addr = MEPC;
        2: addr = MCAUSE;
        default: addr = PCER;
      endcase
      op  = csr_op_e'(rand_bits(2));
      acc = (rand_bits(3) != 0);  // some cycles with access low
      drive_cycle(acc, addr, op, rand_bits(32));
      read_csr(addr);
    end

    // trap from IF, mret, trap from ID against a mepc write, mret
    drive_cycle(1'b1, MSTATUS, OP_WRITE, 32'h8);  // mie on, mpie off
    nxt_save   = 1'b1;
    nxt_sel_if = 1'b1;
    nxt_pc_if  = rand_bits(32);
    nxt_pc_id  = rand_bits(32);
    nxt_cause  = 6'h0b;
    idle_cycle();
    read_csr(MEPC);
    read_csr(MCAUSE);
    read_csr(MSTATUS);
    nxt_mret = 1'b1;
    idle_cycle();
    read_csr(MSTATUS);
    nxt_save   = 1'b1;
    nxt_sel_if = 1'b0;
    nxt_pc_if  = rand_bits(32);
    nxt_pc_id  = rand_bits(32);
    nxt_cause  = 6'h27;  // interrupt, code 7
    drive_cycle(1'b1, MEPC, OP_WRITE, 32'hdead_beef);
    model_expect(MEPC, nxt_pc_id);
    read_csr(MEPC);
    read_csr(MCAUSE);
    read_csr(MSTATUS);
    nxt_mret = 1'b1;
    idle_cycle();
    read_csr(MSTATUS);

    // load and store counters from known start values
    drive_cycle(1'b1, PCMR, OP_WRITE, 32'h3);
    drive_cycle(1'b1, PCER, OP_WRITE, 32'h60);
    drive_cycle(1'b1, 12'(PCCR_BASE + 5), OP_WRITE, 32'h100);
    drive_cycle(1'b1, 12'(PCCR_BASE + 6), OP_WRITE, 32'h2000);
    drive_cycle(1'b1, PCCR_BASE, OP_WRITE, 32'h55);  // cycle counter stays disabled
    n_load  = 0;
    n_store = 0;
    repeat (40) begin
      nxt_load  = rand_bits(1);
      nxt_store = rand_bits(1);
      n_load    = n_load + nxt_load;
      n_store   = n_store + nxt_store;
      idle_cycle();
    end
    nxt_load  = 1'b0;
    nxt_store = 1'b0;
    repeat (2) idle_cycle();
    model_expect(12'(PCCR_BASE + 5), 32'h100 + n_load);
    model_expect(12'(PCCR_BASE + 6), 32'h2000 + n_store);
    model_expect(PCCR_BASE, 32'h55);
    read_csr(12'(PCCR_BASE + 5));
    read_csr(12'(PCCR_BASE + 6));
    read_csr(PCCR_BASE);
    // nothing moves with the global enable off
    drive_cycle(1'b1, PCMR, OP_CLEAR, 32'h1);
    repeat (10) begin
      nxt_load  = rand_bits(1);
      nxt_store = rand_bits(1);
      idle_cycle();
    end
    nxt_load  = 1'b0;
    nxt_store = 1'b0;
    repeat (2) idle_cycle();
    model_expect(12'(PCCR_BASE + 5), 32'h100 + n_load);
    model_expect(12'(PCCR_BASE + 6), 32'h2000 + n_store);
    read_csr(12'(PCCR_BASE + 5));
    read_csr(12'(PCCR_BASE + 6));

    // saturate, then wrap
    run_cycle_counter(1'b1, 32'hFFFF_FFFF);
    run_cycle_counter(1'b0, 32'h0000_0002);

    // all-counter write, then the two external events
    drive_cycle(1'b1, PCER, OP_WRITE, 32'h1800);
    drive_cycle(1'b1, PCMR, OP_WRITE, 32'h3);
    drive_cycle(1'b1, PCCR_ALL, OP_WRITE, 32'h0000_0a00);
    for (int c = 0; c < N_CNT; c++) begin
      model_expect(12'(PCCR_BASE + c), 32'h0a00);
      read_csr(12'(PCCR_BASE + c));
    end
    n_ext0 = 0;
    n_ext1 = 0;
    repeat (30) begin
      nxt_ext = 2'(rand_bits(2));
      n_ext0  = n_ext0 + nxt_ext[0];
      n_ext1  = n_ext1 + nxt_ext[1];
      idle_cycle();
    end
    nxt_ext = '0;
    repeat (2) idle_cycle();
    model_expect(12'(PCCR_BASE + 11), 32'h0a00 + n_ext0);
    model_expect(12'(PCCR_BASE + 12), 32'h0a00 + n_ext1);
    model_expect(12'(PCCR_BASE + 20), 32'h0);
    read_csr(12'(PCCR_BASE + 11));
    read_csr(12'(PCCR_BASE + 12));
    read_csr(12'(PCCR_BASE + 20));  // past the last counter
    read_csr(PCCR_ALL);
    @(posedge clk);
    @(negedge clk);  // last cycle compared
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verif
verilog/csr_pkg.sv
verilog/csr_access_ctrl.sv
verilog/machine_trap_regs.sv
verilog/perf_event_ctrl.sv
verilog/perf_counter_bank.sv
verilog/csr_file.sv
verif/tb_csr_file.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the csr_file testbench with verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_file \
    -f list.f -Mdir obj_dir &&
  ./obj_dir/Vtb_csr_file ||
  { echo "csr_file simulation failed" >&2; exit 1; }
